/* source/ifmap_pkg.sv */
`default_nettype none

package ifmap_pkg;

	// Feature map geometry
	localparam int MAP_SIZE = 32;
	localparam int ADDR_W = 10;
	localparam int ROW_W = 5;
	localparam int FETCH_W = 8;
	localparam int SPIKES_PER_PKT = 5;

	// Window scan over the map
	localparam int NUM_PE = 10;
	localparam int PE_W = 4;
	localparam int LAST_ROW_OFFSET = 27;
	localparam int LAST_COL_OFFSET = 27;
	localparam int COL_STEP = 3;

	// Mesh addresses with PE 0 in the lowest slot
	localparam int NODE_W = 4;
	localparam logic [NODE_W-1:0] SRC_NODE = 4'b0000;
	localparam logic [NUM_PE-1:0][NODE_W-1:0] PE_NODE = {
		4'b1110, 4'b1010, 4'b0110, 4'b0010, 4'b1101,
		4'b1001, 4'b0101, 4'b0001, 4'b1100, 4'b1000
	};

	// Packet format
	localparam int PKT_W = 35;
	localparam logic [2:0] PKT_TYPE_SPIKE = 3'b001;
	localparam int CTRL_W = 27;
	localparam logic [CTRL_W-1:0] CTRL_DONE = 27'd1;
	localparam int PAD_W = PKT_W - 2 * NODE_W - 3 - SPIKES_PER_PKT;

	typedef union packed {
		struct packed {
			logic [NODE_W-1:0] src;
			logic [NODE_W-1:0] dst;
			logic [2:0] ptype;
			logic [PAD_W-1:0] pad;
			logic [SPIKES_PER_PKT-1:0] spikes;
		} spike;
		struct packed {
			logic [NODE_W-1:0] src;
			logic [NODE_W-1:0] dst;
			logic [CTRL_W-1:0] word;
		} ctrl;
	} pkt_t;

	// Scanner FSM encoding
	localparam int STATE_W = 3;
	localparam logic [STATE_W-1:0] S_IDLE = 3'd0;
	localparam logic [STATE_W-1:0] S_ISSUE = 3'd1;
	localparam logic [STATE_W-1:0] S_WAIT_WIN = 3'd2;
	localparam logic [STATE_W-1:0] S_WAIT_MAP = 3'd3;
	localparam logic [STATE_W-1:0] S_FINISH = 3'd4;

endpackage

`default_nettype wire

/* source/ifmap_store.sv */
`timescale 1ns/1ps
`default_nettype none

module ifmap_store (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             load_valid,
	input  wire                             load_map,
	input  wire  [ifmap_pkg::ADDR_W-1:0]    load_addr,
	input  wire                             load_spike,
	input  wire                             fetch_valid,
	input  wire                             fetch_map,
	input  wire  [ifmap_pkg::ROW_W-1:0]     fetch_row,
	input  wire  [ifmap_pkg::ROW_W-1:0]     fetch_col,
	input  wire  [ifmap_pkg::PE_W-1:0]      fetch_pe,
	output logic                            row_valid,
	output logic [ifmap_pkg::FETCH_W-1:0]   row_bits,
	output logic [ifmap_pkg::PE_W-1:0]      row_pe,
	output logic                            maps_loaded
);
	import ifmap_pkg::*;

	// One word per row, bit n holds column n
	logic [MAP_SIZE-1:0] rows [2][MAP_SIZE];
	logic [ADDR_W:0] load_count [2];
	logic [ROW_W-1:0] load_row;
	logic [ROW_W-1:0] load_col;
	logic [2*MAP_SIZE-1:0] row_wide;
	logic [FETCH_W-1:0] fetch_slice;

	assign load_row = load_addr[ADDR_W-1:ROW_W];
	assign load_col = load_addr[ROW_W-1:0];

	always_ff @(posedge clk) begin
		if (load_valid) begin
			rows[load_map][load_row][load_col] <= load_spike;
		end
	end

	// Top bit set means 1024 writes seen, and the count holds there
	always_ff @(posedge clk) begin
		if (reset) begin
			load_count[0] <= '0;
			load_count[1] <= '0;
		end else if (load_valid && !load_count[load_map][ADDR_W]) begin
			load_count[load_map] <= load_count[load_map] + 1'b1;
		end
	end

	assign maps_loaded = load_count[0][ADDR_W] & load_count[1][ADDR_W];

	// Zero fill past the right edge of the map
	always_comb begin
		row_wide = {{MAP_SIZE{1'b0}}, rows[fetch_map][fetch_row]} >> fetch_col;
		for (int i = 0; i < FETCH_W; i++) begin
			fetch_slice[FETCH_W-1-i] = row_wide[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			row_valid <= 1'b0;
		end else begin
			row_valid <= fetch_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			row_bits <= fetch_slice;
			row_pe <= fetch_pe;
		end
	end

endmodule

`default_nettype wire

/* source/window_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module window_scanner (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             start,
	input  wire                             maps_loaded,
	input  wire                             ctrl_valid,
	input  wire  ifmap_pkg::pkt_t           ctrl_pkt,
	output logic                            fetch_valid,
	output logic                            fetch_map,
	output logic [ifmap_pkg::ROW_W-1:0]     fetch_row,
	output logic [ifmap_pkg::ROW_W-1:0]     fetch_col,
	output logic [ifmap_pkg::PE_W-1:0]      fetch_pe,
	output logic                            busy,
	output logic                            scan_done
);
	import ifmap_pkg::*;

	logic [STATE_W-1:0] state;
	logic [ROW_W-1:0] row_off;
	logic [ROW_W-1:0] col_off;
	logic done_pkt;
	logic last_pe;
	logic last_col;
	logic last_row;

	// Only a done word counts, other control traffic is dropped
	assign done_pkt = ctrl_valid && (ctrl_pkt.ctrl.word == CTRL_DONE);

	assign last_pe = (fetch_pe == PE_W'(NUM_PE - 1));
	assign last_col = (col_off == ROW_W'(LAST_COL_OFFSET));
	assign last_row = (row_off == ROW_W'(LAST_ROW_OFFSET));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			fetch_pe <= '0;
			fetch_map <= 1'b0;
			row_off <= '0;
			col_off <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start && maps_loaded) begin
						state <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					if (last_pe) begin
						fetch_pe <= '0;
						state <= S_WAIT_WIN;
					end else begin
						fetch_pe <= fetch_pe + 1'b1;
					end
				end
				S_WAIT_WIN: begin
					if (done_pkt) begin
						state <= S_ISSUE;
						if (!last_col) begin
							col_off <= col_off + ROW_W'(COL_STEP);
						end else begin
							col_off <= '0;
							if (!last_row) begin
								row_off <= row_off + 1'b1;
							end else begin
								row_off <= '0;
								state <= fetch_map ? S_FINISH : S_WAIT_MAP;
							end
						end
					end
				end
				// Map 1 needs one more done before map 2 starts
				S_WAIT_MAP: begin
					if (done_pkt) begin
						fetch_map <= 1'b1;
						state <= S_ISSUE;
					end
				end
				S_FINISH: begin
					fetch_map <= 1'b0;
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	assign fetch_valid = (state == S_ISSUE);

	// Two PEs per window row, odd PEs take the right half
	assign fetch_row = row_off + ROW_W'(fetch_pe[PE_W-1:1]);
	assign fetch_col = col_off + (fetch_pe[0] ? ROW_W'(COL_STEP) : '0);

	assign busy = (state != S_IDLE);
	assign scan_done = (state == S_FINISH);

endmodule

`default_nettype wire

/* source/packet_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_builder (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             row_valid,
	input  wire  [ifmap_pkg::FETCH_W-1:0]   row_bits,
	input  wire  [ifmap_pkg::PE_W-1:0]      row_pe,
	output logic                            pkt_valid,
	output ifmap_pkg::pkt_t                 pkt
);
	import ifmap_pkg::*;

	pkt_t pkt_next;

	always_comb begin
		pkt_next.spike.src = SRC_NODE;
		pkt_next.spike.dst = PE_NODE[row_pe];
		pkt_next.spike.ptype = PKT_TYPE_SPIKE;
		pkt_next.spike.pad = '0;
		// Leftmost window column goes out in the top bit
		pkt_next.spike.spikes = row_bits[FETCH_W-1 -: SPIKES_PER_PKT];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pkt_valid <= 1'b0;
		end else begin
			pkt_valid <= row_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (row_valid) begin
			pkt <= pkt_next;
		end
	end

endmodule

`default_nettype wire

/* source/ifmap_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ifmap_loader_top (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             load_valid,
	input  wire                             load_map,
	input  wire  [ifmap_pkg::ADDR_W-1:0]    load_addr,
	input  wire                             load_spike,
	input  wire                             start,
	input  wire                             ctrl_valid,
	input  wire  ifmap_pkg::pkt_t           ctrl_pkt,
	output logic                            pkt_valid,
	output ifmap_pkg::pkt_t                 pkt,
	output logic                            busy,
	output logic                            scan_done
);
	import ifmap_pkg::*;

	wire fetch_valid;
	wire fetch_map;
	wire [ROW_W-1:0] fetch_row;
	wire [ROW_W-1:0] fetch_col;
	wire [PE_W-1:0] fetch_pe;
	wire row_valid;
	wire [FETCH_W-1:0] row_bits;
	wire [PE_W-1:0] row_pe;
	wire maps_loaded;

	ifmap_store u_store (
		.clk         (clk),
		.reset       (reset),
		.load_valid  (load_valid),
		.load_map    (load_map),
		.load_addr   (load_addr),
		.load_spike  (load_spike),
		.fetch_valid (fetch_valid),
		.fetch_map   (fetch_map),
		.fetch_row   (fetch_row),
		.fetch_col   (fetch_col),
		.fetch_pe    (fetch_pe),
		.row_valid   (row_valid),
		.row_bits    (row_bits),
		.row_pe      (row_pe),
		.maps_loaded (maps_loaded)
	);

	window_scanner u_scanner (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.maps_loaded (maps_loaded),
		.ctrl_valid  (ctrl_valid),
		.ctrl_pkt    (ctrl_pkt),
		.fetch_valid (fetch_valid),
		.fetch_map   (fetch_map),
		.fetch_row   (fetch_row),
		.fetch_col   (fetch_col),
		.fetch_pe    (fetch_pe),
		.busy        (busy),
		.scan_done   (scan_done)
	);

	packet_builder u_builder (
		.clk       (clk),
		.reset     (reset),
		.row_valid (row_valid),
		.row_bits  (row_bits),
		.row_pe    (row_pe),
		.pkt_valid (pkt_valid),
		.pkt       (pkt)
	);

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	// Release lines up with the drive point just after the edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* test/tb_ifmap_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ifmap_loader;
	import ifmap_pkg::*;

	localparam int WINDOWS = 280;
	localparam int PKTS_PER_MAP = 2800;
	// Packet visible after the second edge and taken by a receiver on the third
	localparam int LATENCY = 2;
	localparam int TIMEOUT_CYCLES = 2 * WINDOWS * 40 + 2 * 1024 + 2000;

	logic clk;
	logic reset;
	logic load_valid;
	logic load_map;
	logic [ADDR_W-1:0] load_addr;
	logic load_spike;
	logic start;
	logic ctrl_valid;
	pkt_t ctrl_pkt;
	logic pkt_valid;
	pkt_t pkt;
	logic busy;
	logic scan_done;

	logic map_bits [2][1024];
	logic [31:0] rng_state = 32'hbe0461e7;
	int errors = 0;
	int pkts_checked = 0;
	int pkts_seen = 0;
	int done_pulses = 0;

	clock_gen #(.PERIOD(20), .RESET_CYCLES(5)) u_clock (.clk(clk), .reset(reset));

	ifmap_loader_top dut (
		.clk        (clk),
		.reset      (reset),
		.load_valid (load_valid),
		.load_map   (load_map),
		.load_addr  (load_addr),
		.load_spike (load_spike),
		.start      (start),
		.ctrl_valid (ctrl_valid),
		.ctrl_pkt   (ctrl_pkt),
		.pkt_valid  (pkt_valid),
		.pkt        (pkt),
		.busy       (busy),
		.scan_done  (scan_done)
	);

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Mesh node of each processing element
	function automatic logic [3:0] pe_node(input int pe);
		case (pe)
			0: return 4'b1000;
			1: return 4'b1100;
			2: return 4'b0001;
			3: return 4'b0101;
			4: return 4'b1001;
			5: return 4'b1101;
			6: return 4'b0010;
			7: return 4'b0110;
			8: return 4'b1010;
			9: return 4'b1110;
			default: return 4'b0000;
		endcase
	endfunction

	// Odd PEs see the right half of the window row with the first column in the top bit
	function automatic logic [34:0] expected_pkt(input int map, input int row_off,
			input int col_off, input int pe);
		logic [4:0] spikes;
		int row;
		int col;
		row = row_off + pe / 2;
		for (int k = 0; k < 5; k++) begin
			col = col_off + 3 * (pe % 2) + k;
			if (col < 32) begin
				spikes[4 - k] = map_bits[map][row * 32 + col];
			end else begin
				spikes[4 - k] = 1'b0;
			end
		end
		return {4'b0000, pe_node(pe), 3'b001, 19'd0, spikes};
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
		if (scan_done === 1'b1) begin
			done_pulses++;
		end
		if (pkt_valid === 1'b1) begin
			pkts_seen++;
		end
	endtask

	task automatic report_mismatch(input string test, input logic [63:0] expected,
			input logic [63:0] actual);
		errors++;
		$display("CHECK FAILED %s: expected %h, actual %h", test, expected, actual);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR: %s", msg);
	endtask

	task automatic load_spikes(input int map, input int first, input int last);
		logic [31:0] r;
		for (int a = first; a <= last; a++) begin
			r = next_random();
			map_bits[map][a] = r[11];
			load_valid = 1'b1;
			load_map = map[0];
			load_addr = a[9:0];
			load_spike = r[11];
			next_cycle();
		end
		load_valid = 1'b0;
	endtask

	task automatic expect_quiet(input string test, input int cycles);
		for (int i = 0; i < cycles; i++) begin
			next_cycle();
			if (pkt_valid !== 1'b0) begin
				report_mismatch({test, " pkt_valid while waiting"}, 0, pkt_valid);
			end
		end
	endtask

	task automatic send_ctrl(input logic [26:0] word);
		ctrl_pkt = {4'b0101, 4'b0000, word};
		ctrl_valid = 1'b1;
		next_cycle();
		ctrl_valid = 1'b0;
	endtask

	task automatic pulse_start();
		start = 1'b1;
		next_cycle();
		start = 1'b0;
	endtask

	// Called on the cycle after the edge that took start or done
	task automatic check_window(input string test, input int map, input int row_off,
			input int col_off);
		logic [34:0] expected;
		string where;
		int wait_cycles;
		wait_cycles = 0;
		while (pkt_valid !== 1'b1 && wait_cycles < 8) begin
			next_cycle();
			wait_cycles++;
		end
		if (pkt_valid !== 1'b1) begin
			report_error($sformatf("%s: no packet arrived for map %0d window row %0d col %0d",
				test, map + 1, row_off, col_off));
		end else begin
			if (wait_cycles != LATENCY) begin
				report_mismatch({test, " first packet latency"}, LATENCY, wait_cycles);
			end
			for (int pe = 0; pe < 10; pe++) begin
				expected = expected_pkt(map, row_off, col_off, pe);
				where = $sformatf("%s map %0d row %0d col %0d pe %0d", test, map + 1,
					row_off, col_off, pe);
				if (pkt_valid !== 1'b1) begin
					report_mismatch({where, " pkt_valid"}, 1, pkt_valid);
				end else if (pkt !== expected) begin
					report_mismatch(where, expected, pkt);
				end
				if (col_off == 27 && pe % 2 == 1 && pkt[2:0] !== 3'b000) begin
					report_mismatch({where, " edge spikes"}, 0, pkt[2:0]);
				end
				pkts_checked++;
				next_cycle();
			end
			if (pkt_valid !== 1'b0) begin
				report_mismatch({test, " extra packet after window"}, 0, pkt_valid);
			end
		end
	endtask

	// Withholds done for a random time and now and then sends a non-done word first
	task automatic release_window(input string test, input int idx);
		logic [31:0] r;
		r = next_random();
		if (idx % 7 == 3) begin
			send_ctrl(27'h2a5a5a5);
			expect_quiet({test, " ignored control"}, 4);
		end
		expect_quiet(test, r[3:0]);
		send_ctrl(27'd1);
	endtask

	task automatic test_reset();
		for (int i = 0; i < 20; i++) begin
			next_cycle();
			if ({pkt_valid, busy, scan_done} !== 3'b000) begin
				report_mismatch("reset_idle", 3'b000, {pkt_valid, busy, scan_done});
			end
		end
	endtask

	task automatic test_early_start();
		load_spikes(0, 0, 1023);
		load_spikes(1, 0, 1022);
		pulse_start();
		for (int i = 0; i < 30; i++) begin
			if ({busy, pkt_valid} !== 2'b00) begin
				report_mismatch("early_start", 2'b00, {busy, pkt_valid});
			end
			next_cycle();
		end
		load_spikes(1, 1023, 1023);
	endtask

	task automatic test_first_window();
		pulse_start();
		if (busy !== 1'b1) begin
			report_mismatch("first_window busy", 1, busy);
		end
		check_window("first_window", 0, 0, 0);
	endtask

	task automatic test_map1_scan();
		for (int idx = 1; idx < WINDOWS; idx++) begin
			release_window("map1_scan", idx);
			check_window("map1_scan", 0, idx / 10, (idx % 10) * 3);
		end
		if (pkts_seen != PKTS_PER_MAP) begin
			report_mismatch("map1_scan packet count", PKTS_PER_MAP, pkts_seen);
		end
	endtask

	task automatic test_map2_scan();
		release_window("map2_scan", WINDOWS);
		expect_quiet("map2_scan extra done", 20);
		if (busy !== 1'b1) begin
			report_mismatch("map2_scan busy between maps", 1, busy);
		end
		send_ctrl(27'd1);
		check_window("map2_scan", 1, 0, 0);
		for (int idx = 1; idx < WINDOWS; idx++) begin
			release_window("map2_scan", idx);
			check_window("map2_scan", 1, idx / 10, (idx % 10) * 3);
		end
		if (done_pulses != 0) begin
			report_mismatch("map2_scan early scan_done", 0, done_pulses);
		end
		release_window("map2_scan", WINDOWS + 1);
		expect_quiet("map2_scan after last done", 10);
		if (done_pulses != 1) begin
			report_mismatch("map2_scan scan_done pulses", 1, done_pulses);
		end
		if (busy !== 1'b0) begin
			report_mismatch("map2_scan busy after scan", 0, busy);
		end
		if (pkts_seen != 2 * PKTS_PER_MAP) begin
			report_mismatch("map2_scan packet count", 2 * PKTS_PER_MAP, pkts_seen);
		end
	endtask

	initial begin
		load_valid = 1'b0;
		load_map = 1'b0;
		load_addr = '0;
		load_spike = 1'b0;
		start = 1'b0;
		ctrl_valid = 1'b0;
		ctrl_pkt = '0;
		@(negedge reset);
		test_reset();
		test_early_start();
		test_first_window();
		test_map1_scan();
		test_map2_scan();
		$display("packets checked: %0d, errors: %0d", pkts_checked, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles, the scan did not finish",
			TIMEOUT_CYCLES);
		$display("packets checked: %0d, errors: %0d", pkts_checked, errors + 1);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
source/ifmap_pkg.sv
source/ifmap_store.sv
source/window_scanner.sv
source/packet_builder.sv
source/ifmap_loader_top.sv
test/clock_gen.sv
test/tb_ifmap_loader.sv
